// File: uart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART shared constants
// Widths, register map and field positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package uart_pkg;

  localparam int DATA_W     = 8;       // Byte payload
  localparam int ADDR_W     = 12;      // Decoded part of the bus address
  localparam int FIFO_DEPTH = 8;
  localparam int CNT_W      = 4;       // Holds 0 to FIFO_DEPTH
  localparam int DIV_W      = 16;

  localparam logic [DIV_W-1:0] DIV_RESET = 16'h021e;

  // Register offsets
  localparam logic [ADDR_W-1:0] OFS_TXDATA = 12'h000;
  localparam logic [ADDR_W-1:0] OFS_RXDATA = 12'h004;
  localparam logic [ADDR_W-1:0] OFS_TXCTRL = 12'h008;
  localparam logic [ADDR_W-1:0] OFS_RXCTRL = 12'h00c;
  localparam logic [ADDR_W-1:0] OFS_IE     = 12'h010;
  localparam logic [ADDR_W-1:0] OFS_IP     = 12'h014;
  localparam logic [ADDR_W-1:0] OFS_DIV    = 12'h018;

  // Field positions
  localparam int FLAG_BIT  = 31;       // Full in txdata, empty in rxdata
  localparam int EN_BIT    = 0;
  localparam int WM_LSB    = 16;
  localparam int IE_TX_BIT = 0;
  localparam int IE_RX_BIT = 1;

  localparam int RX_SYNC_W  = 3;
  localparam int FRAME_BITS = 8;       // Data bits per frame

endpackage

`default_nettype wire

// File: uart_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous byte FIFO with count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter int DEPTH = uart_pkg::FIFO_DEPTH    // Power of two
) (
  input  logic                          ri2ziyy,
  input  logic                          r46kf,
  input  logic                          i_push,
  input  logic [uart_pkg::DATA_W-1:0]   i_wdata,
  input  logic                          i_pop,
  output logic [uart_pkg::DATA_W-1:0]   o_rdata,
  output logic [uart_pkg::CNT_W-1:0]    o_count
);

  logic [uart_pkg::DATA_W-1:0]  mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic                         push_ok;
  logic                         pop_ok;

  assign push_ok = i_push & (o_count != DEPTH[uart_pkg::CNT_W-1:0]);
  assign pop_ok  = i_pop & (o_count != '0);
  assign o_rdata = mem[rd_ptr];         // Head visible with pop

  always_ff @(posedge ri2ziyy)
  begin
    if (push_ok)
      mem[wr_ptr] <= i_wdata;
  end

  always_ff @(posedge ri2ziyy or negedge r46kf)
  begin
    if (!r46kf)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;        // Wraps at DEPTH
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   o_count <= o_count + 1'b1;
        2'b01:   o_count <= o_count - 1'b1;
        default: o_count <= o_count;
      endcase
    end
  end

  count_bound: assert property (@(posedge ri2ziyy) disable iff (!r46kf)
    o_count <= DEPTH[uart_pkg::CNT_W-1:0]);

endmodule

`default_nettype wire

// File: uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmit engine
// Sends 8N1 frames at the divisor rate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                          ri2ziyy,
  input  logic                          r46kf,
  input  logic                          i_en,
  input  logic [uart_pkg::DIV_W-1:0]    i_div,
  input  logic [uart_pkg::CNT_W-1:0]    i_count,
  input  logic [uart_pkg::DATA_W-1:0]   i_data,
  output logic                          o_pop,
  output logic                          o_txd
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t                    state;
  logic [uart_pkg::DIV_W-1:0]   baud_cnt;
  logic                         tick;
  logic [2:0]                   bit_idx;
  logic                         last_bit;
  logic [uart_pkg::DATA_W-1:0]  shift;

  assign tick     = (baud_cnt == i_div);      // Last cycle of a bit
  assign last_bit = (bit_idx == 3'(uart_pkg::FRAME_BITS - 1));
  assign o_pop    = (state == TX_IDLE) & i_en & (i_count != '0);

  always_ff @(posedge ri2ziyy)
  begin
    if (o_pop)
      shift <= i_data;
    else if ((state == TX_DATA) && tick)
      shift <= shift >> 1;
  end

  always_ff @(posedge ri2ziyy or negedge r46kf)
  begin
    if (!r46kf)
    begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      o_txd    <= 1'b1;
    end
    else if (!i_en)
    begin
      state    <= TX_IDLE;              // Frame in flight is dropped
      baud_cnt <= '0;
      bit_idx  <= '0;
      o_txd    <= 1'b1;
    end
    else
    begin
      if ((state == TX_IDLE) || tick)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        TX_IDLE:
        begin
          if (o_pop)
          begin
            state <= TX_START;
            o_txd <= 1'b0;
          end
        end
        TX_START:
        begin
          if (tick)
          begin
            state   <= TX_DATA;
            bit_idx <= '0;
            o_txd   <= shift[0];
          end
        end
        TX_DATA:
        begin
          if (tick)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (last_bit)
            begin
              state <= TX_STOP;
              o_txd <= 1'b1;
            end
            else
              o_txd <= shift[1];        // Next bit before the shift lands
          end
        end
        TX_STOP:
        begin
          if (tick)
            state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  txd_idle_high: assert property (@(posedge ri2ziyy) disable iff (!r46kf)
    (state == TX_IDLE) |-> o_txd);

endmodule

`default_nettype wire

// File: uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receive engine
// Syncs the line, votes three samples a bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                          ri2ziyy,
  input  logic                          r46kf,
  input  logic                          i_en,
  input  logic [uart_pkg::DIV_W-1:0]    i_div,
  input  logic                          i_rxd,
  output logic                          o_push,
  output logic [uart_pkg::DATA_W-1:0]   o_data
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t                        state;
  logic [uart_pkg::RX_SYNC_W-1:0]   sync;
  logic                             line;
  logic                             fall;
  logic [uart_pkg::DIV_W-1:0]       baud_cnt;
  logic [uart_pkg::DIV_W-1:0]       pt_a;
  logic [uart_pkg::DIV_W-1:0]       pt_b;
  logic [uart_pkg::DIV_W-1:0]       pt_c;
  logic                             tick;
  logic                             smp_a;
  logic                             smp_b;
  logic                             smp_c;
  logic                             maj;
  logic [2:0]                       bit_idx;
  logic                             last_bit;
  logic [uart_pkg::DATA_W-1:0]      shift;

  assign line = sync[uart_pkg::RX_SYNC_W-1];
  assign fall = line & ~sync[uart_pkg::RX_SYNC_W-2];     // High then low

  assign pt_a = i_div >> 2;
  assign pt_b = i_div >> 1;
  assign pt_c = pt_a + pt_b + 1'b1;

  assign tick     = (baud_cnt == i_div);
  assign maj      = (smp_a & smp_b) | (smp_a & smp_c) | (smp_b & smp_c);
  assign last_bit = (bit_idx == 3'(uart_pkg::FRAME_BITS - 1));
  assign o_push   = (state == RX_STOP) & tick & i_en;
  assign o_data   = shift;

  always_ff @(posedge ri2ziyy or negedge r46kf)
  begin
    if (!r46kf)
      sync <= '1;
    else if (!i_en)
      sync <= '1;                       // Idle line level
    else
      sync <= {sync[uart_pkg::RX_SYNC_W-2:0], i_rxd};
  end

  always_ff @(posedge ri2ziyy)
  begin
    if (baud_cnt == pt_a)
      smp_a <= line;
    if (baud_cnt == pt_b)
      smp_b <= line;
    if (baud_cnt == pt_c)
      smp_c <= line;
    if ((state == RX_DATA) && tick)
      shift <= {maj, shift[uart_pkg::DATA_W-1:1]};   // LSB first
  end

  always_ff @(posedge ri2ziyy or negedge r46kf)
  begin
    if (!r46kf)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!i_en)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      if ((state == RX_IDLE) || tick)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        RX_IDLE:
        begin
          if (fall)
            state <= RX_START;
        end
        RX_START:
        begin
          if (tick)
          begin
            state   <= maj ? RX_IDLE : RX_DATA;   // High vote is a glitch
            bit_idx <= '0;
          end
        end
        RX_DATA:
        begin
          if (tick)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (last_bit)
              state <= RX_STOP;
          end
        end
        RX_STOP:
        begin
          if (tick)
            state <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  push_single: assert property (@(posedge ri2ziyy) disable iff (!r46kf)
    o_push |=> !o_push);

endmodule

`default_nettype wire

// File: uart_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART register block
// Bus decode, configuration and interrupts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_regs (
  input  logic                          ri2ziyy,
  input  logic                          r46kf,
  input  logic                          i_cmd_valid,
  input  logic [uart_pkg::ADDR_W-1:0]   i_cmd_addr,
  input  logic                          i_cmd_read,
  input  logic [31:0]                   i_cmd_wdata,
  input  logic                          i_rsp_ready,
  input  logic [uart_pkg::CNT_W-1:0]    i_tx_count,
  input  logic [uart_pkg::CNT_W-1:0]    i_rx_count,
  input  logic [uart_pkg::DATA_W-1:0]   i_rx_rdata,
  output logic                          o_cmd_ready,
  output logic                          o_rsp_valid,
  output logic [31:0]                   o_rsp_rdata,
  output logic                          o_tx_push,
  output logic [uart_pkg::DATA_W-1:0]   o_tx_wdata,
  output logic                          o_rx_pop,
  output logic                          o_tx_en,
  output logic                          o_rx_en,
  output logic [uart_pkg::DIV_W-1:0]    o_div,
  output logic                          o_irq
);

  logic                         cmd_fire;
  logic                         wr_fire;
  logic                         rd_fire;
  logic                         tx_full;
  logic                         rx_empty;
  logic                         tx_ip;
  logic                         rx_ip;
  logic                         ie_tx;
  logic                         ie_rx;
  logic [uart_pkg::CNT_W-1:0]   tx_wm;
  logic [uart_pkg::CNT_W-1:0]   rx_wm;

  assign o_cmd_ready = i_rsp_ready;    // Response path never holds a command
  assign o_rsp_valid = i_cmd_valid;
  assign cmd_fire    = i_cmd_valid & i_rsp_ready;
  assign wr_fire     = cmd_fire & ~i_cmd_read;
  assign rd_fire     = cmd_fire & i_cmd_read;

  assign tx_full  = (i_tx_count == uart_pkg::FIFO_DEPTH[uart_pkg::CNT_W-1:0]);
  assign rx_empty = (i_rx_count == '0);

  assign o_tx_push  = wr_fire & (i_cmd_addr == uart_pkg::OFS_TXDATA) & ~tx_full;
  assign o_tx_wdata = i_cmd_wdata[uart_pkg::DATA_W-1:0];
  assign o_rx_pop   = rd_fire & (i_cmd_addr == uart_pkg::OFS_RXDATA) & ~rx_empty;

  always_ff @(posedge ri2ziyy or negedge r46kf)
  begin
    if (!r46kf)
    begin
      o_tx_en <= 1'b0;
      o_rx_en <= 1'b0;
      tx_wm   <= '0;
      rx_wm   <= '0;
      ie_tx   <= 1'b0;
      ie_rx   <= 1'b0;
      o_div   <= uart_pkg::DIV_RESET;
    end
    else if (wr_fire)
    begin
      case (i_cmd_addr)
        uart_pkg::OFS_TXCTRL:
        begin
          o_tx_en <= i_cmd_wdata[uart_pkg::EN_BIT];
          tx_wm   <= i_cmd_wdata[uart_pkg::WM_LSB +: uart_pkg::CNT_W];
        end
        uart_pkg::OFS_RXCTRL:
        begin
          o_rx_en <= i_cmd_wdata[uart_pkg::EN_BIT];
          rx_wm   <= i_cmd_wdata[uart_pkg::WM_LSB +: uart_pkg::CNT_W];
        end
        uart_pkg::OFS_IE:
        begin
          ie_tx <= i_cmd_wdata[uart_pkg::IE_TX_BIT];
          ie_rx <= i_cmd_wdata[uart_pkg::IE_RX_BIT];
        end
        uart_pkg::OFS_DIV: o_div <= i_cmd_wdata[uart_pkg::DIV_W-1:0];
        default: ;
      endcase
    end
  end

  // Watermark pending bits are level, not sticky
  assign tx_ip = (i_tx_count < tx_wm);
  assign rx_ip = (i_rx_count > rx_wm);
  assign o_irq = (tx_ip & ie_tx) | (rx_ip & ie_rx);

  always_comb
  begin
    o_rsp_rdata = '0;
    case (i_cmd_addr)
      uart_pkg::OFS_TXDATA: o_rsp_rdata[uart_pkg::FLAG_BIT] = tx_full;
      uart_pkg::OFS_RXDATA:
      begin
        o_rsp_rdata[uart_pkg::FLAG_BIT]       = rx_empty;
        o_rsp_rdata[uart_pkg::DATA_W-1:0]     = i_rx_rdata;   // FIFO head
      end
      uart_pkg::OFS_TXCTRL:
      begin
        o_rsp_rdata[uart_pkg::EN_BIT]                     = o_tx_en;
        o_rsp_rdata[uart_pkg::WM_LSB +: uart_pkg::CNT_W]  = tx_wm;
      end
      uart_pkg::OFS_RXCTRL:
      begin
        o_rsp_rdata[uart_pkg::EN_BIT]                     = o_rx_en;
        o_rsp_rdata[uart_pkg::WM_LSB +: uart_pkg::CNT_W]  = rx_wm;
      end
      uart_pkg::OFS_IE:
      begin
        o_rsp_rdata[uart_pkg::IE_TX_BIT] = ie_tx;
        o_rsp_rdata[uart_pkg::IE_RX_BIT] = ie_rx;
      end
      uart_pkg::OFS_IP:
      begin
        o_rsp_rdata[uart_pkg::IE_TX_BIT] = tx_ip;
        o_rsp_rdata[uart_pkg::IE_RX_BIT] = rx_ip;
      end
      uart_pkg::OFS_DIV: o_rsp_rdata[uart_pkg::DIV_W-1:0] = o_div;
      default: ;
    endcase
  end

  // The receive count never rises across a pop
  rx_pop_legal: assert property (@(posedge ri2ziyy) disable iff (!r46kf)
    o_rx_pop |=> (i_rx_count <= $past(i_rx_count)));

endmodule

`default_nettype wire

// File: uart_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-mapped UART top level
// Registers, two FIFOs, TX and RX engines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic          ri2ziyy,
  input  logic          r46kf,
  input  logic          i_cmd_valid,
  input  logic [31:0]   i_cmd_addr,
  input  logic          i_cmd_read,
  input  logic [31:0]   i_cmd_wdata,
  input  logic          i_rsp_ready,
  input  logic          i_rxd,
  output logic          o_cmd_ready,
  output logic          o_rsp_valid,
  output logic [31:0]   o_rsp_rdata,
  output logic          o_irq,
  output logic          o_txd
);

  logic                         tx_push;
  logic [uart_pkg::DATA_W-1:0]  tx_wdata;
  logic                         tx_pop;
  logic [uart_pkg::DATA_W-1:0]  tx_rdata;
  logic [uart_pkg::CNT_W-1:0]   tx_count;
  logic                         rx_push;
  logic [uart_pkg::DATA_W-1:0]  rx_wdata;
  logic                         rx_pop;
  logic [uart_pkg::DATA_W-1:0]  rx_rdata;
  logic [uart_pkg::CNT_W-1:0]   rx_count;
  logic                         tx_en;
  logic                         rx_en;
  logic [uart_pkg::DIV_W-1:0]   div;

  uart_regs u_regs (
    .ri2ziyy     (ri2ziyy),
    .r46kf       (r46kf),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_addr  (i_cmd_addr[uart_pkg::ADDR_W-1:0]),   // 4 KB window
    .i_cmd_read  (i_cmd_read),
    .i_cmd_wdata (i_cmd_wdata),
    .i_rsp_ready (i_rsp_ready),
    .i_tx_count  (tx_count),
    .i_rx_count  (rx_count),
    .i_rx_rdata  (rx_rdata),
    .o_cmd_ready (o_cmd_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .o_tx_push   (tx_push),
    .o_tx_wdata  (tx_wdata),
    .o_rx_pop    (rx_pop),
    .o_tx_en     (tx_en),
    .o_rx_en     (rx_en),
    .o_div       (div),
    .o_irq       (o_irq)
  );

  uart_fifo u_tx_fifo (
    .ri2ziyy (ri2ziyy),
    .r46kf   (r46kf),
    .i_push  (tx_push),
    .i_wdata (tx_wdata),
    .i_pop   (tx_pop),
    .o_rdata (tx_rdata),
    .o_count (tx_count)
  );

  uart_fifo u_rx_fifo (
    .ri2ziyy (ri2ziyy),
    .r46kf   (r46kf),
    .i_push  (rx_push),
    .i_wdata (rx_wdata),
    .i_pop   (rx_pop),
    .o_rdata (rx_rdata),
    .o_count (rx_count)
  );

  uart_tx u_tx (
    .ri2ziyy (ri2ziyy),
    .r46kf   (r46kf),
    .i_en    (tx_en),
    .i_div   (div),
    .i_count (tx_count),
    .i_data  (tx_rdata),
    .o_pop   (tx_pop),
    .o_txd   (o_txd)
  );

  uart_rx u_rx (
    .ri2ziyy (ri2ziyy),
    .r46kf   (r46kf),
    .i_en    (rx_en),
    .i_div   (div),
    .i_rxd   (i_rxd),
    .o_push  (rx_push),
    .o_data  (rx_wdata)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial
  begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;                     // Release away from the rising edge
  end

endmodule

`default_nettype wire

// File: tb_uart_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART directed testbench
// Bus register access, serial frames, IRQ
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

  localparam logic [31:0] A_TXDATA = 32'h00;
  localparam logic [31:0] A_RXDATA = 32'h04;
  localparam logic [31:0] A_TXCTRL = 32'h08;
  localparam logic [31:0] A_RXCTRL = 32'h0c;
  localparam logic [31:0] A_IE     = 32'h10;
  localparam logic [31:0] A_IP     = 32'h14;
  localparam logic [31:0] A_DIV    = 32'h18;

  localparam int DIV         = 7;
  localparam int BIT_CYC     = DIV + 1;
  localparam int N_FRAMES    = 4 + 9 + 1;       // Transmit, receive, interrupt tests
  localparam int CYCLE_LIMIT = N_FRAMES * 10 * BIT_CYC + 2000;

  logic         ri2ziyy;
  logic         r46kf;
  logic         cmd_valid;
  logic [31:0]  cmd_addr;
  logic         cmd_read;
  logic [31:0]  cmd_wdata;
  logic         rsp_ready;
  logic         rxd;
  logic         cmd_ready;
  logic         rsp_valid;
  logic [31:0]  rsp_rdata;
  logic         irq;
  logic         txd;

  logic [31:0]  lfsr_state;
  int           err_count = 0;
  int           check_count = 0;
  int           cycle_count = 0;

  tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clkgen (
    .o_clk   (ri2ziyy),
    .o_rst_n (r46kf)
  );

  uart_top dut (
    .ri2ziyy     (ri2ziyy),
    .r46kf       (r46kf),
    .i_cmd_valid (cmd_valid),
    .i_cmd_addr  (cmd_addr),
    .i_cmd_read  (cmd_read),
    .i_cmd_wdata (cmd_wdata),
    .i_rsp_ready (rsp_ready),
    .i_rxd       (rxd),
    .o_cmd_ready (cmd_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp_rdata (rsp_rdata),
    .o_irq       (irq),
    .o_txd       (txd)
  );

  always @(posedge ri2ziyy)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      b[i] = lfsr_state[0];
    end
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic log_test_result(input string name, input int errs_before);
    $display("%s: %s, %0d errors", name, (err_count == errs_before) ? "ok" : "failed",
             err_count - errs_before);
  endtask

  task automatic bus_xfer(input logic rd, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(negedge ri2ziyy);
    cmd_valid = 1'b1;
    cmd_read  = rd;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    rsp_ready = 1'b1;
    #2;
    while (!cmd_ready && waited < 16)
    begin
      @(negedge ri2ziyy);
      #2;
      waited++;
    end
    if (!cmd_ready)
    begin
      $display("Bus command to address %h was never accepted", addr);
      err_count++;
    end
    else
    begin
      expect_eq("o_rsp_valid", {31'b0, rsp_valid}, 32'd1);
      rdata = rsp_rdata;                // State before the accepting edge
      @(posedge ri2ziyy);
    end
    @(negedge ri2ziyy);
    cmd_valid = 1'b0;
    cmd_read  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_xfer(1'b0, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_xfer(1'b1, addr, 32'h0, rdata);
  endtask

  task automatic read_check(input string what, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] r;
    bus_read(addr, r);
    expect_eq(what, r, exp);
  endtask

  // 8N1 on i_rxd followed by one idle bit time
  task automatic send_frame(input logic [7:0] data);
    logic [9:0] bits;
    bits = {1'b1, data, 1'b0};
    @(negedge ri2ziyy);
    for (int i = 0; i < 10; i++)
    begin
      rxd = bits[i];
      repeat (BIT_CYC) @(negedge ri2ziyy);
    end
    repeat (BIT_CYC) @(negedge ri2ziyy);
  endtask

  task automatic recv_frame(output logic [7:0] data);
    int waited;
    waited = 0;
    data = '0;
    @(negedge ri2ziyy);
    while (txd !== 1'b0 && waited < 40 * BIT_CYC)
    begin
      @(negedge ri2ziyy);
      waited++;
    end
    if (txd !== 1'b0)
    begin
      $display("No start bit appeared on o_txd");
      err_count++;
    end
    else
    begin
      repeat (BIT_CYC / 2 - 1) @(negedge ri2ziyy);   // Middle of the start bit
      expect_eq("start bit", {31'b0, txd}, 32'd0);
      for (int i = 0; i < 8; i++)
      begin
        repeat (BIT_CYC) @(negedge ri2ziyy);
        data[i] = txd;
      end
      repeat (BIT_CYC) @(negedge ri2ziyy);
      expect_eq("stop bit", {31'b0, txd}, 32'd1);
    end
  endtask

  task automatic test_reset_state();
    int errs0;
    logic [31:0] r;
    errs0 = err_count;
    read_check("div after reset", A_DIV, 32'h0000_021e);
    read_check("txctrl after reset", A_TXCTRL, 32'h0);
    read_check("rxctrl after reset", A_RXCTRL, 32'h0);
    read_check("ie after reset", A_IE, 32'h0);
    read_check("ip after reset", A_IP, 32'h0);
    read_check("txdata after reset", A_TXDATA, 32'h0);
    bus_read(A_RXDATA, r);
    expect_eq("rxdata empty flag after reset", {31'b0, r[31]}, 32'd1);
    expect_eq("o_txd after reset", {31'b0, txd}, 32'd1);
    expect_eq("o_irq after reset", {31'b0, irq}, 32'd0);
    log_test_result("reset state", errs0);
  endtask

  task automatic test_register_fields();
    int errs0;
    errs0 = err_count;
    bus_write(A_TXCTRL, 32'hffff_ffff);
    bus_write(A_RXCTRL, 32'hffff_ffff);
    bus_write(A_IE, 32'hffff_ffff);
    bus_write(A_DIV, 32'hffff_ffff);
    read_check("txctrl fields", A_TXCTRL, 32'h000f_0001);
    read_check("rxctrl fields", A_RXCTRL, 32'h000f_0001);
    read_check("ie fields", A_IE, 32'h0000_0003);
    read_check("div fields", A_DIV, 32'h0000_ffff);
    @(negedge ri2ziyy);
    cmd_valid = 1'b1;                   // Stalled write
    cmd_read  = 1'b0;
    cmd_addr  = A_DIV;
    cmd_wdata = 32'h0000_1234;
    rsp_ready = 1'b0;
    repeat (3)
    begin
      #2;
      expect_eq("o_cmd_ready under back-pressure", {31'b0, cmd_ready}, 32'd0);
      @(negedge ri2ziyy);
    end
    cmd_valid = 1'b0;
    rsp_ready = 1'b1;
    read_check("div after stalled write", A_DIV, 32'h0000_ffff);
    bus_write(A_TXCTRL, 32'h0);
    bus_write(A_RXCTRL, 32'h0);
    bus_write(A_IE, 32'h0);
    log_test_result("register fields", errs0);
  endtask

  task automatic test_transmit();
    int errs0;
    logic [7:0] sent [$];
    logic [7:0] b;
    logic [7:0] got;
    errs0 = err_count;
    bus_write(A_DIV, DIV);
    for (int i = 0; i < 4; i++)
    begin
      next_byte(b);
      sent.push_back(b);
      bus_write(A_TXDATA, {24'h0, b});
    end
    bus_write(A_TXCTRL, 32'h1);         // Queue is filled before enabling
    for (int i = 0; i < 4; i++)
    begin
      recv_frame(got);
      expect_eq($sformatf("tx byte %0d", i), {24'h0, got}, {24'h0, sent[i]});
    end
    bus_write(A_TXCTRL, 32'h0);
    log_test_result("transmit", errs0);
  endtask

  task automatic test_receive_overflow();
    int errs0;
    logic [7:0] sent [$];
    logic [7:0] b;
    logic [31:0] r;
    errs0 = err_count;
    bus_write(A_RXCTRL, 32'h1);
    for (int i = 0; i < 9; i++)
    begin
      next_byte(b);
      sent.push_back(b);
      send_frame(b);
    end
    for (int i = 0; i < 8; i++)
    begin
      bus_read(A_RXDATA, r);
      expect_eq($sformatf("rxdata %0d", i), r, {24'h0, sent[i]});
    end
    bus_read(A_RXDATA, r);              // Ninth byte was dropped
    expect_eq("rxdata empty flag after overflow", {31'b0, r[31]}, 32'd1);
    bus_write(A_RXCTRL, 32'h0);
    log_test_result("receive and overflow", errs0);
  endtask

  task automatic test_interrupts();
    int errs0;
    int waited;
    logic [7:0] b;
    logic [31:0] r;
    errs0 = err_count;
    waited = 0;
    bus_write(A_TXCTRL, 32'h0001_0000);
    read_check("ip with tx below watermark", A_IP, 32'h1);
    expect_eq("o_irq with ie clear", {31'b0, irq}, 32'd0);
    bus_write(A_IE, 32'h1);
    expect_eq("o_irq with tx enabled", {31'b0, irq}, 32'd1);
    bus_write(A_IE, 32'h2);
    bus_write(A_RXCTRL, 32'h1);
    expect_eq("o_irq before rx frame", {31'b0, irq}, 32'd0);
    next_byte(b);
    send_frame(b);
    while (irq !== 1'b1 && waited < 4 * BIT_CYC)
    begin
      @(negedge ri2ziyy);
      waited++;
    end
    expect_eq("o_irq after rx frame", {31'b0, irq}, 32'd1);
    read_check("ip with both pending", A_IP, 32'h3);
    bus_read(A_RXDATA, r);
    expect_eq("rx byte for interrupt", r, {24'h0, b});
    expect_eq("o_irq after drain", {31'b0, irq}, 32'd0);
    bus_write(A_IE, 32'h0);
    bus_write(A_TXCTRL, 32'h0);
    bus_write(A_RXCTRL, 32'h0);
    log_test_result("interrupts", errs0);
  endtask

  initial
  begin
    cmd_valid  = 1'b0;
    cmd_addr   = 32'h0;
    cmd_read   = 1'b0;
    cmd_wdata  = 32'h0;
    rsp_ready  = 1'b1;
    rxd        = 1'b1;                  // Idle line
    lfsr_state = 32'h71f7_b40b;
    @(posedge r46kf);
    @(negedge ri2ziyy);
    test_reset_state();
    test_register_fields();
    test_transmit();
    test_receive_overflow();
    test_interrupts();
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_top.f
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_clkgen.sv
tb_uart_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_uart_top \
	  -f uart_top.f --Mdir obj_dir -o sim_uart
	./obj_dir/sim_uart > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
